//--- verilog/audio_pkg.sv
`default_nettype none

package audio_pkg;

    // Widths of the audio and volume paths
    localparam int AUDIO_W  = 8;                          // Unsigned sample width
    localparam int VOLUME_W = 4;                          // Speaker volume width

    // One unsigned audio sample where 0 means silence
    typedef logic [AUDIO_W-1:0] audio_sample_t;

    // Speaker volume setting from 0 to 15
    typedef logic [VOLUME_W-1:0] volume_t;

    // Full product of a sample and a volume before the shift
    typedef logic [AUDIO_W+VOLUME_W-1:0] spk_product_t;

    // Sample doubled by the overdrive, one carry bit above a sample
    typedef logic [AUDIO_W:0] audio_wide_t;

    localparam audio_sample_t AUDIO_MAX = '1;             // Clip level of the overdrive

    // Noise gate decision
    localparam audio_sample_t GATE_THRESHOLD = 8'd64;     // Loud at or above this level
    localparam int GATE_HOLD_SAMPLES = 4;                 // Strobes held after last loud one

    // Speaker scaling drops the low bits of the product
    localparam int VOLUME_SHIFT = 4;

endpackage : audio_pkg

`default_nettype wire

//--- verilog/talk_ctrl_pkg.sv
`default_nettype none

package talk_ctrl_pkg;

    // Direction of the half-duplex channel
    // Two bits wide so the encoding can grow later
    typedef enum logic [1:0] {
        LISTEN = 2'b00,                                   // Speaker path open
        TALK   = 2'b01                                    // Microphone path open
    } talk_state_t;

    // Hold counter of the microphone level detector
    typedef logic [2:0] hold_count_t;                     // Counts down from the hold time

endpackage : talk_ctrl_pkg

`default_nettype wire

//--- verilog/mic_level_detect.sv
`timescale 1ns/1ps
`default_nettype none

module mic_level_detect (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample_en,            // One strobe per audio sample
    input  audio_pkg::audio_sample_t mic_aud,             // Microphone sample
    output logic                    mic_loud              // Level held across short pauses
);

    import audio_pkg::*;
    import talk_ctrl_pkg::*;

    localparam hold_count_t HOLD_LOAD = hold_count_t'(GATE_HOLD_SAMPLES); // Reload value

    hold_count_t hold_cnt;                                // Strobes left in the hold window
    logic        sample_loud;                             // Current sample passes the gate

    // Threshold compare on the raw sample
    assign sample_loud = (mic_aud >= GATE_THRESHOLD);

    // A loud strobe restarts the hold window
    // Quiet strobes run it down to zero
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hold_cnt <= '0;                               // Start out quiet
        end else if (sample_en) begin
            if (sample_loud) begin
                hold_cnt <= HOLD_LOAD;                    // Restart the hold
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;              // One quiet strobe used up
            end
        end
    end

    // Loud for as long as the window is open
    assign mic_loud = (hold_cnt != '0);

endmodule : mic_level_detect

`default_nettype wire

//--- verilog/talk_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module talk_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mic_loud,           // Held noise gate decision
    input  logic                      ng_en,              // Noise gate enable
    input  logic                      ptt_en,             // Push-to-talk enable
    input  logic                      effect,             // Voice effect selected
    input  logic                      mute,               // Speaker mute
    input  audio_pkg::audio_sample_t  spk_aud,            // Remote audio
    output talk_ctrl_pkg::talk_state_t state,             // Current direction
    output logic                      eff_en,             // Transmit effect enable
    output logic                      vol_en              // Speaker enable
);

    import talk_ctrl_pkg::*;

    talk_state_t current_state;                           // Registered direction
    talk_state_t next_state;                              // Direction for the next cycle
    logic        spk_active;                              // Remote side is sending
    logic        want_talk;                               // Local side asks for the channel
    logic        drop_talk;                               // Local side lets go of the channel

    // Speaker activity is any non-silent remote sample
    assign spk_active = (spk_aud != '0);

    // Push-to-talk wins over the gate
    assign want_talk = ptt_en || (ng_en && mic_loud);

    // Both enables off, or the gate alone with a quiet mic
    assign drop_talk = (!ptt_en && !ng_en) || (ng_en && !ptt_en && !mic_loud);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            current_state <= LISTEN;
        end else begin
            current_state <= next_state;
        end
    end

    // Next state, listen direction has priority
    always_comb begin
        next_state = current_state;                       // Hold by default
        case (current_state)
            LISTEN: begin
                if (!spk_active && want_talk) begin
                    next_state = TALK;                    // Channel is free and wanted
                end
            end
            TALK: begin
                if (spk_active || drop_talk) begin
                    next_state = LISTEN;                  // Remote barged in or released
                end
            end
            default: next_state = LISTEN;                 // Recover from unused code
        endcase
    end

    assign state = current_state;

    // Path enables follow the state only
    always_comb begin
        vol_en = 1'b0;
        eff_en = 1'b0;
        case (current_state)
            LISTEN:  vol_en = !mute;                      // Speaker unless muted
            TALK:    eff_en = effect;                     // Effect only while talking
            default: begin
                vol_en = 1'b0;
                eff_en = 1'b0;
            end
        endcase
    end

endmodule : talk_fsm

`default_nettype wire

//--- verilog/voice_effect.sv
`timescale 1ns/1ps
`default_nettype none

module voice_effect (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_en,         // Sample strobe
    input  logic                       eff_en,            // Overdrive enable
    input  audio_pkg::audio_sample_t   mic_aud,           // Microphone sample
    input  talk_ctrl_pkg::talk_state_t state,             // Current direction
    output audio_pkg::audio_sample_t   tx_aud,            // Transmit sample
    output logic                       tx_valid           // One cycle after the strobe
);

    import audio_pkg::*;
    import talk_ctrl_pkg::*;

    audio_wide_t   doubled;                               // Twice the sample with carry
    audio_sample_t driven;                                // Overdrive clipped to range
    audio_sample_t tx_next;                               // Sample to register

    // Shift left by one, the top bit shows an overflow
    assign doubled = {mic_aud, 1'b0};

    // Saturate instead of wrapping around
    assign driven = doubled[AUDIO_W] ? AUDIO_MAX : doubled[AUDIO_W-1:0];

    // Silence outside TALK, effect only when enabled
    always_comb begin
        if (state != TALK) begin
            tx_next = '0;                                 // Channel belongs to the far end
        end else if (eff_en) begin
            tx_next = driven;
        end else begin
            tx_next = mic_aud;                            // Clean voice
        end
    end

    // Output register, loads only on a strobe
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tx_aud <= '0;
        end else if (sample_en) begin
            tx_aud <= tx_next;
        end
    end

    // Valid pulse lines up with the registered sample
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= sample_en;
        end
    end

endmodule : voice_effect

`default_nettype wire

//--- verilog/speaker_volume.sv
`timescale 1ns/1ps
`default_nettype none

module speaker_volume (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sample_en,           // Sample strobe
    input  logic                     vol_en,              // Speaker enable
    input  audio_pkg::audio_sample_t spk_aud,             // Remote sample
    input  audio_pkg::volume_t       volume,              // Volume setting
    output audio_pkg::audio_sample_t spk_out,             // Scaled speaker sample
    output logic                     spk_valid            // One cycle after the strobe
);

    import audio_pkg::*;

    spk_product_t  product;                               // Full width sample times volume
    audio_sample_t scaled;                                // Product with low bits dropped
    audio_sample_t spk_next;                              // Sample to register

    // Widen both operands so nothing is lost
    assign product = spk_product_t'(spk_aud) * spk_product_t'(volume);

    // Max is 255 * 15 / 16 so the result always fits a sample
    assign scaled = audio_sample_t'(product >> VOLUME_SHIFT);

    assign spk_next = vol_en ? scaled : '0;               // Muted or talking gives silence

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            spk_out <= '0;
        end else if (sample_en) begin
            spk_out <= spk_next;                          // Hold between strobes
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            spk_valid <= 1'b0;
        end else begin
            spk_valid <= sample_en;
        end
    end

endmodule : speaker_volume

`default_nettype wire

//--- verilog/intercom_top.sv
`timescale 1ns/1ps
`default_nettype none

module intercom_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_en,         // One strobe per audio sample
    input  logic                       ng_en,             // Noise gate enable
    input  logic                       ptt_en,            // Push-to-talk
    input  logic                       effect,            // Overdrive select
    input  logic                       mute,              // Speaker mute
    input  audio_pkg::audio_sample_t   mic_aud,           // Local microphone
    input  audio_pkg::audio_sample_t   spk_aud,           // Remote audio
    input  audio_pkg::volume_t         volume,            // Speaker volume
    output talk_ctrl_pkg::talk_state_t state,             // Current direction
    output audio_pkg::audio_sample_t   tx_aud,            // Transmit audio
    output audio_pkg::audio_sample_t   spk_out,           // Speaker audio
    output logic                       tx_valid,          // Transmit sample strobe
    output logic                       spk_valid          // Speaker sample strobe
);

    logic mic_loud;                                       // Gate decision with hold
    logic eff_en;                                         // Overdrive active
    logic vol_en;                                         // Speaker path open

    // Noise gate front end
    mic_level_detect i_mic_level_detect (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .mic_aud   (mic_aud),
        .mic_loud  (mic_loud)
    );

    // Direction control
    talk_fsm i_talk_fsm (
        .clk      (clk),
        .rst      (rst),
        .mic_loud (mic_loud),
        .ng_en    (ng_en),
        .ptt_en   (ptt_en),
        .effect   (effect),
        .mute     (mute),
        .spk_aud  (spk_aud),
        .state    (state),
        .eff_en   (eff_en),
        .vol_en   (vol_en)
    );

    // Transmit path
    voice_effect i_voice_effect (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .eff_en    (eff_en),
        .mic_aud   (mic_aud),
        .state     (state),
        .tx_aud    (tx_aud),
        .tx_valid  (tx_valid)
    );

    // Receive path
    speaker_volume i_speaker_volume (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .vol_en    (vol_en),
        .spk_aud   (spk_aud),
        .volume    (volume),
        .spk_out   (spk_out),
        .spk_valid (spk_valid)
    );

endmodule : intercom_top

`default_nettype wire

//--- test/intercom_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module intercom_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       sample_en,          // Sample strobe
    input audio_pkg::audio_sample_t   spk_aud,            // Remote audio
    input talk_ctrl_pkg::talk_state_t state,              // Current direction
    input audio_pkg::audio_sample_t   tx_aud,             // Transmit audio
    input logic                       tx_valid,
    input logic                       spk_valid,
    input logic                       vol_en,             // Internal speaker enable
    input logic                       eff_en              // Internal overdrive enable
);

    import talk_ctrl_pkg::*;

    // Both output stages answer each strobe one cycle later
    valid_after_strobe: assert property (@(posedge clk) disable iff (rst)
        sample_en |=> (tx_valid && spk_valid))
        else $error("Valid pulse missing one cycle after sample_en");

    no_valid_without_strobe: assert property (@(posedge clk) disable iff (rst)
        !sample_en |=> (!tx_valid && !spk_valid))
        else $error("Valid pulse without a sample_en one cycle before");

    // Transmit stays silent for samples taken while listening
    listen_tx_silent: assert property (@(posedge clk) disable iff (rst)
        (sample_en && state == LISTEN) |=> (tx_aud == '0))
        else $error("tx_aud not zero for a sample taken in LISTEN");

    listen_held_by_speaker: assert property (@(posedge clk) disable iff (rst)
        (state == LISTEN && spk_aud != '0) |=> (state == LISTEN))
        else $error("State left LISTEN with remote audio present");

    enables_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(vol_en && eff_en))
        else $error("vol_en and eff_en high at the same time");

endmodule : intercom_assertions

bind intercom_top intercom_assertions i_intercom_assertions (
    .clk       (clk),
    .rst       (rst),
    .sample_en (sample_en),
    .spk_aud   (spk_aud),
    .state     (state),
    .tx_aud    (tx_aud),
    .tx_valid  (tx_valid),
    .spk_valid (spk_valid),
    .vol_en    (vol_en),
    .eff_en    (eff_en)
);

`default_nettype wire

//--- test/intercom_tb.sv
`timescale 1ns/1ps
`default_nettype none

module intercom_tb;

    import audio_pkg::*;
    import talk_ctrl_pkg::*;

    localparam int VALID_TIMEOUT = 16;                    // Cycles allowed for the first valid
    localparam int RANDOM_ROWS   = 24;                    // Random samples per audio path

    typedef struct packed {
        logic          se;                                // Sample strobe
        audio_sample_t mic;
        audio_sample_t spk;
        logic          ng;
        logic          ptt;
        logic          eff;
        logic          mute;
        volume_t       vol;
        talk_state_t   exp_state;                         // State one cycle after the row
        audio_sample_t exp_tx;                            // Checked with the valid pulse
        audio_sample_t exp_spk;
    } row_t;

    localparam int NUM_ROWS = 27;

    // se, mic, spk, ng, ptt, eff, mute, vol, state, tx_aud, spk_out
    localparam row_t ROWS [NUM_ROWS] = '{
        // Speaker path in LISTEN with volume scaling and mute
        '{1'b1, 8'd0, 8'd100, 1'b0, 1'b0, 1'b0, 1'b0, 4'd8, LISTEN, 8'd0, 8'd50},
        '{1'b1, 8'd0, 8'd255, 1'b0, 1'b0, 1'b0, 1'b0, 4'd15, LISTEN, 8'd0, 8'd239},
        '{1'b1, 8'd0, 8'd200, 1'b0, 1'b0, 1'b0, 1'b1, 4'd8, LISTEN, 8'd0, 8'd0},
        '{1'b1, 8'd0, 8'd17, 1'b0, 1'b0, 1'b0, 1'b0, 4'd1, LISTEN, 8'd0, 8'd1},
        // Push-to-talk with clean voice then overdrive
        '{1'b1, 8'd50, 8'd0, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, TALK, 8'd0, 8'd0},
        '{1'b1, 8'd50, 8'd0, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, TALK, 8'd50, 8'd0},
        '{1'b1, 8'd100, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd8, TALK, 8'd200, 8'd0},
        '{1'b1, 8'd200, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd8, TALK, 8'd255, 8'd0},
        '{1'b1, 8'd127, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd8, TALK, 8'd254, 8'd0},
        '{1'b1, 8'd128, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd8, TALK, 8'd255, 8'd0},
        '{1'b0, 8'd0, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd8, TALK, 8'd0, 8'd0},
        // Remote audio takes the channel back even with push-to-talk held
        '{1'b1, 8'd30, 8'd5, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, LISTEN, 8'd30, 8'd0},
        '{1'b1, 8'd30, 8'd5, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, LISTEN, 8'd0, 8'd2},
        '{1'b1, 8'd30, 8'd0, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, TALK, 8'd0, 8'd0},
        '{1'b1, 8'd30, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd8, LISTEN, 8'd30, 8'd0},
        // Noise gate stays closed at 63 and opens one strobe after 64
        '{1'b1, 8'd63, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, LISTEN, 8'd0, 8'd0},
        '{1'b1, 8'd63, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, LISTEN, 8'd0, 8'd0},
        '{1'b1, 8'd64, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, LISTEN, 8'd0, 8'd0},
        '{1'b1, 8'd64, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, TALK, 8'd0, 8'd0},
        '{1'b1, 8'd90, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, TALK, 8'd90, 8'd0},
        // Quiet strobes run the hold down
        '{1'b1, 8'd10, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, TALK, 8'd10, 8'd0},
        '{1'b1, 8'd10, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, TALK, 8'd10, 8'd0},
        '{1'b1, 8'd10, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, TALK, 8'd10, 8'd0},
        '{1'b1, 8'd10, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, TALK, 8'd10, 8'd0},
        '{1'b1, 8'd10, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'd8, LISTEN, 8'd10, 8'd0},
        // Muted speaker then unmuted at low volume
        '{1'b1, 8'd200, 8'd160, 1'b0, 1'b0, 1'b1, 1'b1, 4'd8, LISTEN, 8'd0, 8'd0},
        '{1'b1, 8'd0, 8'd160, 1'b0, 1'b0, 1'b0, 1'b0, 4'd4, LISTEN, 8'd0, 8'd40}
    };

    logic          clk;
    logic          rst;
    logic          sample_en;
    logic          ng_en;
    logic          ptt_en;
    logic          effect;
    logic          mute;
    audio_sample_t mic_aud;
    audio_sample_t spk_aud;
    volume_t       volume;
    talk_state_t   state;
    audio_sample_t tx_aud;
    audio_sample_t spk_out;
    logic          tx_valid;
    logic          spk_valid;

    int            error_count;
    int            check_count;
    logic [15:0]   lfsr_state;                            // Random source for the tail rows

    intercom_top i_intercom_top (
        .clk       (clk),
        .rst       (rst),
        .sample_en (sample_en),
        .ng_en     (ng_en),
        .ptt_en    (ptt_en),
        .effect    (effect),
        .mute      (mute),
        .mic_aud   (mic_aud),
        .spk_aud   (spk_aud),
        .volume    (volume),
        .state     (state),
        .tx_aud    (tx_aud),
        .spk_out   (spk_out),
        .tx_valid  (tx_valid),
        .spk_valid (spk_valid)
    );

    always #5 clk = ~clk;                                 // 100 MHz

    // Taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int k = 0; k < count; k++) begin
            value = {value[6:0], lfsr_bit()};             // Newest bit at the bottom
        end
        return value;
    endfunction

    // Sample times volume with the low bits dropped
    function automatic audio_sample_t scaled_level(input audio_sample_t spk, input volume_t vol);
        int product;
        product = int'(spk) * int'(vol);
        return audio_sample_t'(product >> VOLUME_SHIFT);
    endfunction

    // Doubled sample clipped at full scale
    function automatic audio_sample_t overdriven(input audio_sample_t mic);
        int twice;
        twice = 2 * int'(mic);
        if (twice > 255) begin
            return 8'd255;
        end
        return audio_sample_t'(twice);
    endfunction

    task automatic drive_inputs(input logic se, input audio_sample_t mic, input audio_sample_t spk,
                                input logic ng, input logic ptt, input logic eff,
                                input logic mt, input volume_t vol);
        sample_en = se;
        mic_aud   = mic;
        spk_aud   = spk;
        ng_en     = ng;
        ptt_en    = ptt;
        effect    = eff;
        mute      = mt;
        volume    = vol;
    endtask

    task automatic check_result(input string label, input int idx, input talk_state_t exp_state,
                                input logic exp_valid, input logic check_audio,
                                input audio_sample_t exp_tx, input audio_sample_t exp_spk);
        check_count++;
        if (state !== exp_state) begin
            $display("[FAIL] %0t %s %0d: state expected %s, got %s",
                     $time, label, idx, exp_state.name(), state.name());
            error_count++;
        end
        if (tx_valid !== exp_valid || spk_valid !== exp_valid) begin
            $display("[FAIL] %0t %s %0d: valids expected %b, got tx %b spk %b",
                     $time, label, idx, exp_valid, tx_valid, spk_valid);
            error_count++;
        end
        if (check_audio && tx_aud !== exp_tx) begin
            $display("[FAIL] %0t %s %0d: tx_aud expected %0d, got %0d",
                     $time, label, idx, exp_tx, tx_aud);
            error_count++;
        end
        if (check_audio && spk_out !== exp_spk) begin
            $display("[FAIL] %0t %s %0d: spk_out expected %0d, got %0d",
                     $time, label, idx, exp_spk, spk_out);
            error_count++;
        end
    endtask

    // One row per cycle with its check right after the next edge
    task automatic apply_table();
        row_t row;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = ROWS[i];
            drive_inputs(row.se, row.mic, row.spk, row.ng, row.ptt, row.eff, row.mute, row.vol);
            @(posedge clk);
            #1;
            check_result("table row", i, row.exp_state, row.se, row.se, row.exp_tx, row.exp_spk);
        end
    endtask

    task automatic random_speaker_pass();
        audio_sample_t rnd_spk;
        volume_t       rnd_vol;
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            rnd_spk = random_bits(8);
            rnd_vol = volume_t'(random_bits(4));
            // Loud mic must stay off the transmit path while listening
            drive_inputs(1'b1, 8'd150, rnd_spk, 1'b0, 1'b0, 1'b0, 1'b0, rnd_vol);
            @(posedge clk);
            #1;
            check_result("random speaker row", k, LISTEN, 1'b1, 1'b1, 8'd0,
                         scaled_level(rnd_spk, rnd_vol));
        end
    endtask

    task automatic random_transmit_pass();
        audio_sample_t rnd_mic;
        logic          rnd_eff;
        audio_sample_t want_tx;
        // Push-to-talk opens the channel before the samples
        drive_inputs(1'b0, 8'd0, 8'd0, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8);
        @(posedge clk);
        #1;
        check_result("talk entry", 0, TALK, 1'b0, 1'b0, 8'd0, 8'd0);
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            rnd_mic = random_bits(8);
            rnd_eff = lfsr_bit();
            want_tx = rnd_eff ? overdriven(rnd_mic) : rnd_mic;
            drive_inputs(1'b1, rnd_mic, 8'd0, 1'b0, 1'b1, rnd_eff, 1'b0, 4'd8);
            @(posedge clk);
            #1;
            check_result("random transmit row", k, TALK, 1'b1, 1'b1, want_tx, 8'd0);
        end
    endtask

    initial begin
        int   waited;
        logic got_valid;

        clk         = 1'b0;
        rst         = 1'b1;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 16'd80;
        drive_inputs(1'b0, 8'd0, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);

        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // Idle cycles straight out of reset
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            #1;
            check_result("reset cycle", k, LISTEN, 1'b0, 1'b1, 8'd0, 8'd0);
        end

        // One silent sample and a wait for its valid pulses
        drive_inputs(1'b1, 8'd0, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
        waited    = 0;
        got_valid = 1'b0;
        while (!got_valid && waited < VALID_TIMEOUT) begin
            @(posedge clk);
            #1;
            sample_en = 1'b0;                             // Single strobe only
            waited++;
            got_valid = tx_valid && spk_valid;
        end

        if (!got_valid) begin
            $display("No valid pulse on tx_valid and spk_valid within %0d cycles after reset",
                     VALID_TIMEOUT);
            error_count++;
        end else begin
            apply_table();
            random_speaker_pass();
            random_transmit_pass();
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : intercom_tb

`default_nettype wire

//--- all.f
verilog/audio_pkg.sv
verilog/talk_ctrl_pkg.sv
verilog/mic_level_detect.sv
verilog/talk_fsm.sv
verilog/voice_effect.sv
verilog/speaker_volume.sv
verilog/intercom_top.sv
test/intercom_assertions.sv
test/intercom_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the intercom testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module intercom_tb -f all.f -o intercom_sim \
    && ./obj_dir/intercom_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -qx "Finished with errors" sim.log \
    && { echo "Simulation reported errors"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
